// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // instruction opcodes seen in the write-back stage
    typedef enum logic [3:0] {
        op_mov      = 4'd1,
        op_add      = 4'd2,
        op_sub      = 4'd3,
        op_and      = 4'd4,
        op_or       = 4'd5,
        op_shift    = 4'd6,  // rlc / rrc / setc / clrc
        op_stack_io = 4'd7,  // push / pop / out / in
        op_unary    = 4'd8,  // not / neg / inc / dec
        op_loop     = 4'd10,
        op_call     = 4'd11, // call / ret / rti
        op_load     = 4'd12, // ldm / ldd
        op_ldi      = 4'd13,
        op_hlt      = 4'd15
    } opcode_t;

    // ra field as a sub-op under op_stack_io
    localparam logic [1:0] sub_push = 2'd0;
    localparam logic [1:0] sub_pop  = 2'd1;
    localparam logic [1:0] sub_out  = 2'd2;
    localparam logic [1:0] sub_in   = 2'd3;

    // ra field as a sub-op under op_call
    localparam logic [1:0] sub_call = 2'd1;
    localparam logic [1:0] sub_ret  = 2'd2;
    localparam logic [1:0] sub_rti  = 2'd3;

    // register file geometry
    localparam int num_regs      = 4;
    localparam int reg_sel_width = 2;
    localparam int sp_index      = 3; // R3 is the stack pointer

endpackage

// ==== hw/wb_pkg.sv ====
package wb_pkg;

    // write-back sequencer states
    typedef enum logic [1:0] {
        st_run,
        st_in_wait,
        st_out_wait,
        st_halted
    } wb_state_t;

    // four-phase handshake progress, shared by both I/O ports
    typedef enum logic [1:0] {
        ph_idle,
        ph_req,     // req high, waiting for ack
        ph_release  // req dropped, waiting for ack to fall
    } io_phase_t;

endpackage

// ==== hw/wb_decoder.sv ====
module wb_decoder
    import isa_pkg::*;
(
    input  opcode_t    opcode,
    input  logic [1:0] ra,
    output logic       write_en,
    output logic       dest_rb,  // 1 selects rb as destination
    output logic       data_io,  // 1 selects input port data
    output logic       sp_inc,
    output logic       sp_dec,
    output logic       ld_out,
    output logic       halt
);

    always_comb begin
        write_en = 1'b0;
        dest_rb  = 1'b0;
        data_io  = 1'b0;
        sp_inc   = 1'b0;
        sp_dec   = 1'b0;
        ld_out   = 1'b0;
        halt     = 1'b0;

        case (opcode)
            // alu results and loop counter land in ra
            op_mov, op_add, op_sub, op_and, op_or, op_unary, op_loop: begin
                write_en = 1'b1;
            end

            op_shift: begin
                if (ra == 2'd0 || ra == 2'd1) begin // rlc / rrc only
                    write_en = 1'b1;
                    dest_rb  = 1'b1;
                end
            end

            op_stack_io: begin
                case (ra)
                    sub_push: sp_dec = 1'b1; // memory write done upstream
                    sub_pop: begin
                        sp_inc   = 1'b1;
                        write_en = 1'b1;
                        dest_rb  = 1'b1;
                    end
                    sub_out: ld_out = 1'b1;
                    sub_in: begin
                        write_en = 1'b1;
                        dest_rb  = 1'b1;
                        data_io  = 1'b1;
                    end
                endcase
            end

            op_call: begin
                if (ra == sub_call) begin
                    sp_dec = 1'b1;
                end else if (ra == sub_ret || ra == sub_rti) begin
                    sp_inc = 1'b1;
                end
            end

            op_load: begin
                if (ra == 2'd0 || ra == 2'd1) begin // ldm / ldd
                    write_en = 1'b1;
                    dest_rb  = 1'b1;
                end
            end

            op_ldi: begin
                write_en = 1'b1;
                dest_rb  = 1'b1;
            end

            op_hlt: halt = 1'b1;

            default: ; // unused opcodes do nothing
        endcase
    end

endmodule

// ==== hw/wb_sequencer.sv ====
module wb_sequencer
    import isa_pkg::*;
    import wb_pkg::*;
#(
    parameter int data_width = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ins_valid,
    input  logic [reg_sel_width-1:0] ins_ra,
    input  logic [reg_sel_width-1:0] ins_rb,
    input  logic                     write_en,
    input  logic                     dest_rb,
    input  logic                     data_io,
    input  logic                     sp_inc,
    input  logic                     sp_dec,
    input  logic                     ld_out,
    input  logic                     halt,
    input  logic [data_width-1:0]    ins_wb_data,
    input  logic                     in_done,
    input  logic [data_width-1:0]    in_value,
    input  logic                     in_busy,
    input  logic                     out_busy,
    output logic                     ins_ready,
    output logic                     halted,
    output logic                     wr_en,
    output logic [reg_sel_width-1:0] wr_addr,
    output logic [data_width-1:0]    wr_data,
    output logic                     sp_inc_strobe,
    output logic                     sp_dec_strobe,
    output logic [reg_sel_width-1:0] src_addr,
    output logic                     out_load,
    output logic                     in_start
);

    wb_state_t                  state;
    wb_state_t                  state_nxt;
    logic                       accept;
    logic [reg_sel_width-1:0]   in_dest;   // rb of the pending IN

    assign ins_ready = (state == st_run);
    assign halted    = (state == st_halted);
    assign accept    = ins_valid && ins_ready;

    // controls only count on an accepting edge
    assign sp_inc_strobe = accept && sp_inc;
    assign sp_dec_strobe = accept && sp_dec;
    assign out_load      = accept && ld_out;
    assign in_start      = accept && write_en && data_io;
    assign src_addr      = ins_rb; // OUT reads R[rb]

    always_comb begin
        if (state == st_in_wait) begin
            wr_en   = in_done;
            wr_addr = in_dest;
            wr_data = in_value;
        end else begin
            wr_en   = accept && write_en && !data_io;
            wr_addr = dest_rb ? ins_rb : ins_ra;
            wr_data = ins_wb_data;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_run: begin
                if (accept && halt) begin
                    state_nxt = st_halted;
                end else if (out_load) begin
                    state_nxt = st_out_wait;
                end else if (in_start) begin
                    state_nxt = st_in_wait;
                end
            end
            st_in_wait:  if (!in_busy) state_nxt = st_run;
            st_out_wait: if (!out_busy) state_nxt = st_run;
            st_halted:   state_nxt = st_halted; // only reset gets out
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_run;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (in_start) begin
            in_dest <= ins_rb;
        end
    end

endmodule

// ==== hw/reg_file.sv ====
module reg_file
    import isa_pkg::*;
#(
    parameter int                    data_width = 8,
    parameter logic [data_width-1:0] sp_init    = 8'hFF
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  logic [reg_sel_width-1:0] wr_addr,
    input  logic [data_width-1:0]    wr_data,
    input  logic                     sp_inc,
    input  logic                     sp_dec,
    input  logic [reg_sel_width-1:0] rd_addr_a,
    input  logic [reg_sel_width-1:0] rd_addr_b,
    input  logic [reg_sel_width-1:0] src_addr,
    output logic [data_width-1:0]    rd_data_a,
    output logic [data_width-1:0]    rd_data_b,
    output logic [data_width-1:0]    src_data
);

    logic [data_width-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= (i == sp_index) ? sp_init : '0;
            end
        end else begin
            for (int i = 0; i < num_regs; i++) begin
                if (wr_en && wr_addr == reg_sel_width'(i)) begin
                    regs[i] <= wr_data; // write beats the sp step
                end else if (i == sp_index && sp_inc) begin
                    regs[i] <= regs[i] + 1'b1;
                end else if (i == sp_index && sp_dec) begin
                    regs[i] <= regs[i] - 1'b1;
                end
            end
        end
    end

    // decode-stage ports and the output-port source
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    assign src_data  = regs[src_addr];

endmodule

// ==== hw/out_port.sv ====
module out_port
    import wb_pkg::*;
#(
    parameter int data_width = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,
    input  logic [data_width-1:0] value,
    input  logic                  out_ack,
    output logic [data_width-1:0] out_data,
    output logic                  out_req,
    output logic                  busy
);

    io_phase_t phase;

    assign out_req = (phase == ph_req);
    // drops in the same cycle ack is seen low
    assign busy = (phase == ph_req) || (phase == ph_release && out_ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= ph_idle;
            out_data <= '0;
        end else begin
            case (phase)
                ph_idle: begin
                    if (load) begin
                        out_data <= value; // held past the exchange
                        phase    <= ph_req;
                    end
                end
                ph_req:     if (out_ack) phase <= ph_release;
                ph_release: if (!out_ack) phase <= ph_idle;
                default:    phase <= ph_idle;
            endcase
        end
    end

endmodule

// ==== hw/in_port.sv ====
module in_port
    import wb_pkg::*;
#(
    parameter int data_width = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [data_width-1:0] in_data,
    input  logic                  in_ack,
    output logic                  in_req,
    output logic                  done,
    output logic [data_width-1:0] value,
    output logic                  busy
);

    io_phase_t phase;

    assign in_req = (phase == ph_req);
    assign done   = in_req && in_ack; // one cycle, the capture edge
    assign value  = in_data;          // taken by the register file on done
    assign busy   = in_req || (phase == ph_release && in_ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= ph_idle;
        end else begin
            case (phase)
                ph_idle:    if (start) phase <= ph_req;
                ph_req:     if (in_ack) phase <= ph_release;
                ph_release: if (!in_ack) phase <= ph_idle;
                default:    phase <= ph_idle;
            endcase
        end
    end

endmodule

// ==== hw/wb_subsystem.sv ====
module wb_subsystem
    import isa_pkg::*;
#(
    parameter int                    data_width = 8,
    parameter logic [data_width-1:0] sp_init    = 8'hFF
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ins_valid,
    input  logic [3:0]               ins_opcode,
    input  logic [reg_sel_width-1:0] ins_ra,
    input  logic [reg_sel_width-1:0] ins_rb,
    input  logic [data_width-1:0]    ins_wb_data,
    input  logic [reg_sel_width-1:0] rd_addr_a,
    input  logic [reg_sel_width-1:0] rd_addr_b,
    input  logic [data_width-1:0]    in_data,
    input  logic                     in_ack,
    input  logic                     out_ack,
    output logic                     ins_ready,
    output logic [data_width-1:0]    rd_data_a,
    output logic [data_width-1:0]    rd_data_b,
    output logic                     in_req,
    output logic                     out_req,
    output logic [data_width-1:0]    out_data,
    output logic                     halted
);

    // decoder controls
    logic write_en;
    logic dest_rb;
    logic data_io;
    logic sp_inc;
    logic sp_dec;
    logic ld_out;
    logic halt;

    // sequencer to register file and ports
    logic                     wr_en;
    logic [reg_sel_width-1:0] wr_addr;
    logic [data_width-1:0]    wr_data;
    logic                     sp_inc_strobe;
    logic                     sp_dec_strobe;
    logic [reg_sel_width-1:0] src_addr;
    logic [data_width-1:0]    src_data;
    logic                     out_load;
    logic                     out_busy;
    logic                     in_start;
    logic                     in_done;
    logic [data_width-1:0]    in_value;
    logic                     in_busy;

    wb_decoder wb_decoder_i (
        .opcode   (opcode_t'(ins_opcode)),
        .ra       (ins_ra),
        .write_en (write_en),
        .dest_rb  (dest_rb),
        .data_io  (data_io),
        .sp_inc   (sp_inc),
        .sp_dec   (sp_dec),
        .ld_out   (ld_out),
        .halt     (halt)
    );

    wb_sequencer #(
        .data_width (data_width)
    ) wb_sequencer_i (
        .clk           (clk),
        .rst           (rst),
        .ins_valid     (ins_valid),
        .ins_ra        (ins_ra),
        .ins_rb        (ins_rb),
        .write_en      (write_en),
        .dest_rb       (dest_rb),
        .data_io       (data_io),
        .sp_inc        (sp_inc),
        .sp_dec        (sp_dec),
        .ld_out        (ld_out),
        .halt          (halt),
        .ins_wb_data   (ins_wb_data),
        .in_done       (in_done),
        .in_value      (in_value),
        .in_busy       (in_busy),
        .out_busy      (out_busy),
        .ins_ready     (ins_ready),
        .halted        (halted),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .sp_inc_strobe (sp_inc_strobe),
        .sp_dec_strobe (sp_dec_strobe),
        .src_addr      (src_addr),
        .out_load      (out_load),
        .in_start      (in_start)
    );

    reg_file #(
        .data_width (data_width),
        .sp_init    (sp_init)
    ) reg_file_i (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .sp_inc    (sp_inc_strobe),
        .sp_dec    (sp_dec_strobe),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .src_addr  (src_addr),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .src_data  (src_data)
    );

    out_port #(
        .data_width (data_width)
    ) out_port_i (
        .clk      (clk),
        .rst      (rst),
        .load     (out_load),
        .value    (src_data),
        .out_ack  (out_ack),
        .out_data (out_data),
        .out_req  (out_req),
        .busy     (out_busy)
    );

    in_port #(
        .data_width (data_width)
    ) in_port_i (
        .clk     (clk),
        .rst     (rst),
        .start   (in_start),
        .in_data (in_data),
        .in_ack  (in_ack),
        .in_req  (in_req),
        .done    (in_done),
        .value   (in_value),
        .busy    (in_busy)
    );

endmodule

// ==== testbench/wb_subsystem_checker.sv ====
module wb_subsystem_checker
    import isa_pkg::*;
#(
    parameter int                    data_width = 8,
    parameter logic [data_width-1:0] sp_init    = 8'hFF
) (
    input logic                     clk,
    input logic                     rst,
    input logic                     ins_valid,
    input logic                     ins_ready,
    input logic [3:0]               ins_opcode,
    input logic [reg_sel_width-1:0] ins_ra,
    input logic [reg_sel_width-1:0] ins_rb,
    input logic [data_width-1:0]    ins_wb_data,
    input logic [reg_sel_width-1:0] rd_addr_a,
    input logic [reg_sel_width-1:0] rd_addr_b,
    input logic [data_width-1:0]    rd_data_a,
    input logic [data_width-1:0]    rd_data_b,
    input logic [data_width-1:0]    in_data,
    input logic                     in_ack,
    input logic                     in_req,
    input logic                     out_ack,
    input logic                     out_req,
    input logic [data_width-1:0]    out_data,
    input logic                     halted
);

    logic [data_width-1:0]    shadow [num_regs]; // expected register contents
    logic [data_width-1:0]    exp_out;           // R[rb] at OUT acceptance
    logic [reg_sel_width-1:0] in_dest;
    logic [data_width-1:0]    exp_a;
    logic [data_width-1:0]    exp_b;
    logic                     accept;

    // failure record, read by the testbench
    logic                     failed = 1'b0;
    logic                     err_is_value = 1'b0;
    string                    err_signal = "";
    logic [data_width-1:0]    err_got;
    logic [data_width-1:0]    err_exp;
    time                      err_time;

    assign accept = ins_valid && ins_ready;
    assign exp_a  = shadow[rd_addr_a];
    assign exp_b  = shadow[rd_addr_b];

    task automatic note_failure(input string name, input logic is_value,
                                input logic [data_width-1:0] got,
                                input logic [data_width-1:0] exp);
        failed       = 1'b1;
        err_signal   = name;
        err_is_value = is_value;
        err_got      = got;
        err_exp      = exp;
        err_time     = $time;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                shadow[i] <= (i == sp_index) ? sp_init : '0;
            end
        end else begin
            if (in_req && in_ack) shadow[in_dest] <= in_data; // capture edge
            if (accept) begin
                case (ins_opcode)
                    4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd8, 4'd10: shadow[ins_ra] <= ins_wb_data;
                    4'd6, 4'd12: if (ins_ra < 2'd2) shadow[ins_rb] <= ins_wb_data;
                    4'd13: shadow[ins_rb] <= ins_wb_data;
                    4'd7: begin
                        case (ins_ra)
                            2'd0: shadow[sp_index] <= shadow[sp_index] - 1'b1;
                            2'd1: begin
                                shadow[sp_index] <= shadow[sp_index] + 1'b1;
                                shadow[ins_rb]   <= ins_wb_data; // later NBA, write wins
                            end
                            2'd2: exp_out <= shadow[ins_rb];
                            default: in_dest <= ins_rb;
                        endcase
                    end
                    4'd11: begin
                        if (ins_ra == 2'd1) shadow[sp_index] <= shadow[sp_index] - 1'b1;
                        else if (ins_ra != 2'd0) shadow[sp_index] <= shadow[sp_index] + 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    a_rd_data_a: assert property (@(posedge clk) disable iff (rst) rd_data_a == exp_a)
        else begin
            $error("rd_data_a mismatch");
            note_failure("rd_data_a", 1'b1, $sampled(rd_data_a), $sampled(exp_a));
        end

    a_rd_data_b: assert property (@(posedge clk) disable iff (rst) rd_data_b == exp_b)
        else begin
            $error("rd_data_b mismatch");
            note_failure("rd_data_b", 1'b1, $sampled(rd_data_b), $sampled(exp_b));
        end

    a_out_data: assert property (@(posedge clk) disable iff (rst) out_req |-> out_data == exp_out)
        else begin
            $error("out_data mismatch");
            note_failure("out_data", 1'b1, $sampled(out_data), $sampled(exp_out));
        end

    a_out_start: assert property (@(posedge clk) disable iff (rst)
        accept && ins_opcode == 4'd7 && ins_ra == 2'd2 |=> out_req)
        else begin
            $error("out_req late");
            note_failure("out_req did not rise after OUT", 1'b0, '0, '0);
        end

    a_out_order: assert property (@(posedge clk) disable iff (rst) out_req && !out_ack |=> out_req)
        else begin
            $error("out_req dropped early");
            note_failure("out_req dropped before out_ack", 1'b0, '0, '0);
        end

    a_out_stall: assert property (@(posedge clk) disable iff (rst) out_req || out_ack |-> !ins_ready)
        else begin
            $error("ready during output exchange");
            note_failure("ins_ready high during the output exchange", 1'b0, '0, '0);
        end

    a_in_start: assert property (@(posedge clk) disable iff (rst)
        accept && ins_opcode == 4'd7 && ins_ra == 2'd3 |=> in_req)
        else begin
            $error("in_req late");
            note_failure("in_req did not rise after IN", 1'b0, '0, '0);
        end

    a_in_order: assert property (@(posedge clk) disable iff (rst) in_req && !in_ack |=> in_req)
        else begin
            $error("in_req dropped early");
            note_failure("in_req dropped before in_ack", 1'b0, '0, '0);
        end

    a_in_stall: assert property (@(posedge clk) disable iff (rst) in_req || in_ack |-> !ins_ready)
        else begin
            $error("ready during input exchange");
            note_failure("ins_ready high during the input exchange", 1'b0, '0, '0);
        end

    a_halt_rise: assert property (@(posedge clk) disable iff (rst) accept && ins_opcode == 4'd15 |=> halted)
        else begin
            $error("halted late");
            note_failure("halted did not rise after HLT", 1'b0, '0, '0);
        end

    a_halt_hold: assert property (@(posedge clk) disable iff (rst) halted |-> !ins_ready ##1 halted)
        else begin
            $error("halt not held");
            note_failure("halted state left or ins_ready high while halted", 1'b0, '0, '0);
        end

    a_reset_vals: assert property (@(posedge clk)
        $fell(rst) |-> ins_ready && !in_req && !out_req && !halted && out_data == '0)
        else begin
            $error("bad reset state");
            note_failure("outputs not at their reset values", 1'b0, '0, '0);
        end

endmodule

bind wb_subsystem wb_subsystem_checker #(
    .data_width (data_width),
    .sp_init    (sp_init)
) checker_i (
    .clk         (clk),
    .rst         (rst),
    .ins_valid   (ins_valid),
    .ins_ready   (ins_ready),
    .ins_opcode  (ins_opcode),
    .ins_ra      (ins_ra),
    .ins_rb      (ins_rb),
    .ins_wb_data (ins_wb_data),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .in_data     (in_data),
    .in_ack      (in_ack),
    .in_req      (in_req),
    .out_ack     (out_ack),
    .out_req     (out_req),
    .out_data    (out_data),
    .halted      (halted)
);

// ==== testbench/tb_wb_subsystem.sv ====
module tb_wb_subsystem;

    localparam int stim_cycles    = 100;
    localparam int io_exchanges   = 40;
    localparam int max_delay      = 3;
    localparam int timeout_cycles = 4 * stim_cycles + io_exchanges * 2 * (max_delay + 2);

    logic       clk = 1'b0;
    logic       rst;
    logic       ins_valid;
    logic [3:0] ins_opcode;
    logic [1:0] ins_ra;
    logic [1:0] ins_rb;
    logic [7:0] ins_wb_data;
    logic [1:0] rd_addr_a;
    logic [1:0] rd_addr_b;
    logic [7:0] in_data;
    logic       in_ack;
    logic       out_ack;
    logic       ins_ready;
    logic [7:0] rd_data_a;
    logic [7:0] rd_data_b;
    logic       in_req;
    logic       out_req;
    logic [7:0] out_data;
    logic       halted;
    int         seed = 65;
    int         cycle = 0;

    wb_subsystem #(.data_width(8), .sp_init(8'hFF)) wb_subsystem_i (.*);

    always #5 clk = ~clk;

    // read ports sweep the registers so every write gets observed
    always @(posedge clk) begin
        rd_addr_a <= rd_addr_a + 2'd1;
        rd_addr_b <= 2'($random(seed));
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        if (wb_subsystem_i.checker_i.failed) begin
            if (wb_subsystem_i.checker_i.err_is_value) begin
                $display("** Error at %0t: %s = %h, expected %h",
                         wb_subsystem_i.checker_i.err_time, wb_subsystem_i.checker_i.err_signal,
                         wb_subsystem_i.checker_i.err_got, wb_subsystem_i.checker_i.err_exp);
            end else begin
                $display("check failed at %0t: %s", wb_subsystem_i.checker_i.err_time,
                         wb_subsystem_i.checker_i.err_signal);
            end
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    // output device, random ack delays
    initial begin
        forever begin
            @(posedge clk);
            if (out_req) begin
                repeat (2'($random(seed))) @(posedge clk);
                out_ack <= 1'b1;
                do @(posedge clk); while (out_req);
                repeat (2'($random(seed))) @(posedge clk);
                out_ack <= 1'b0;
            end
        end
    end

    // input device, data valid with ack
    initial begin
        forever begin
            @(posedge clk);
            if (in_req) begin
                repeat (2'($random(seed))) @(posedge clk);
                in_data <= 8'($random(seed));
                in_ack  <= 1'b1;
                do @(posedge clk); while (in_req);
                repeat (2'($random(seed))) @(posedge clk);
                in_ack  <= 1'b0;
                in_data <= 8'($random(seed)); // stale data must not land
            end
        end
    end

    // call right after a rising edge, returns after the accepting edge
    task automatic issue(input logic [3:0] op, input logic [1:0] ra, input logic [1:0] rb,
                         input logic [7:0] data);
        ins_valid   <= 1'b1;
        ins_opcode  <= op;
        ins_ra      <= ra;
        ins_rb      <= rb;
        ins_wb_data <= data;
        @(posedge clk);
        while (!ins_ready) @(posedge clk);
        ins_valid <= 1'b0;
    endtask

    task automatic issue_random(input logic [3:0] op, input logic [1:0] ra);
        issue(op, ra, 2'($random(seed)), 8'($random(seed)));
    endtask

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        logic [3:0] op;
        rst = 1'b1;
        ins_valid = 1'b0;
        ins_opcode = 4'd0;
        ins_ra = 2'd0;
        ins_rb = 2'd0;
        ins_wb_data = 8'd0;
        rd_addr_a = 2'd0;
        rd_addr_b = 2'd0;
        in_data = 8'd0;
        in_ack = 1'b0;
        out_ack = 1'b0;
        apply_reset();

        for (int i = 0; i < 4; i++) issue_random(4'd1 + 4'(i), 2'(i)); // ra writers
        issue_random(4'd5, 2'd0);
        issue_random(4'd8, 2'd1);
        issue_random(4'd10, 2'd2);
        for (int r = 0; r < 4; r++) begin
            issue_random(4'd6, 2'(r));  // rb only for ra 0 and 1
            issue_random(4'd12, 2'(r));
        end
        issue_random(4'd13, 2'd3);
        issue_random(4'd0, 2'd1);       // unused opcodes
        issue_random(4'd9, 2'd2);
        issue_random(4'd14, 2'd3);

        issue(4'd13, 2'd0, 2'd3, 8'hFF); // sp = FF, RET wraps to 00
        issue(4'd11, 2'd2, 2'd0, 8'h00);
        issue(4'd7, 2'd0, 2'd0, 8'h00);  // PUSH wraps back to FF
        issue(4'd11, 2'd1, 2'd0, 8'h00);
        issue(4'd11, 2'd3, 2'd0, 8'h00);
        issue_random(4'd7, 2'd1);        // POP
        issue(4'd7, 2'd1, 2'd3, 8'h5A);  // POP into the stack pointer

        for (int i = 0; i < 4; i++) begin
            issue_random(4'd7, 2'd2);    // OUT
            issue_random(4'd7, 2'd3);    // IN
        end
        issue_random(4'd7, 2'd2);
        issue_random(4'd1, 2'd0);        // right after an exchange

        for (int i = 0; i < 40; i++) begin
            op = 4'($random(seed));
            if (op == 4'd15) op = 4'd13;
            issue_random(op, 2'($random(seed)));
        end

        issue_random(4'd15, 2'd0);
        ins_valid   <= 1'b1;             // offered but never taken
        ins_opcode  <= 4'd13;
        ins_wb_data <= 8'hA5;
        repeat (6) @(posedge clk);
        ins_valid <= 1'b0;
        apply_reset();
        issue_random(4'd2, 2'd1);
        issue_random(4'd7, 2'd2);
        @(posedge clk);
        while (!ins_ready) @(posedge clk); // last output exchange done
        @(negedge clk);

        if (wb_subsystem_i.checker_i.failed) begin
            $display("TEST FAIL");
            $fatal(1);
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== wb_subsystem.f ====
hw/isa_pkg.sv
hw/wb_pkg.sv
hw/wb_decoder.sv
hw/wb_sequencer.sv
hw/reg_file.sv
hw/out_port.sv
hw/in_port.sv
hw/wb_subsystem.sv
testbench/wb_subsystem_checker.sv
testbench/tb_wb_subsystem.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_wb_subsystem
DUT_TOP    ?= wb_subsystem
FILELIST   ?= wb_subsystem.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert --timing
RUN_ARGS   ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "TEST PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
